// File: hdl/sort_pkg.sv
`default_nettype none

package sort_pkg;

	//////////////////////////////
	// widths

	localparam int COORD_W = 8;   // grid is 256 x 256
	localparam int COST_W = 16;   // worst case cost is 7140
	localparam int INDEX_W = 9;   // 0 to 400 inclusive

	//////////////////////////////
	// open list

	localparam int OPEN_DEPTH = 400;

	//////////////////////////////
	// octile step weights

	localparam int STRAIGHT_STEP = 10;
	localparam int DIAGONAL_STEP = 14;   // about 10 * sqrt(2)

	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [COST_W-1:0] cost_t;
	typedef logic [INDEX_W-1:0] index_t;

endpackage

`default_nettype wire

// File: hdl/octile_cost.sv
`timescale 1ns/1ps
`default_nettype none

module octile_cost import sort_pkg::*;
(
	input  coord_t node_x,
	input  coord_t node_y,
	input  coord_t start_x,
	input  coord_t start_y,
	input  coord_t goal_x,
	input  coord_t goal_y,
	output cost_t  cost
);

	coord_t dx_start;
	coord_t dy_start;
	coord_t dx_goal;
	coord_t dy_goal;
	cost_t  dist_start;
	cost_t  dist_goal;

	function automatic coord_t abs_diff(input coord_t a, input coord_t b);
		return (a > b) ? a - b : b - a;
	endfunction

	// diagonal steps cover the short leg, straight steps the rest
	function automatic cost_t octile(input coord_t dx, input coord_t dy);
		coord_t small_d;
		coord_t large_d;
		small_d = (dx < dy) ? dx : dy;
		large_d = (dx < dy) ? dy : dx;
		return cost_t'(DIAGONAL_STEP) * cost_t'(small_d)
			+ cost_t'(STRAIGHT_STEP) * cost_t'(large_d - small_d);
	endfunction

	assign dx_start = abs_diff(node_x, start_x);
	assign dy_start = abs_diff(node_y, start_y);
	assign dx_goal = abs_diff(node_x, goal_x);
	assign dy_goal = abs_diff(node_y, goal_y);

	assign dist_start = octile(dx_start, dy_start);   // g part
	assign dist_goal = octile(dx_goal, dy_goal);      // h part

	assign cost = dist_start + dist_goal;   // max 7140, no overflow

endmodule

`default_nettype wire

// File: hdl/open_list_mem.sv
`timescale 1ns/1ps
`default_nettype none

module open_list_mem import sort_pkg::*;
(
	input  logic   Clk,
	input  logic   Reset,
	input  logic   load_en,
	input  index_t load_addr,
	input  coord_t load_x,
	input  coord_t load_y,
	input  logic   busy,
	input  index_t pair_index,
	input  logic   swap,
	input  index_t read_addr,
	output coord_t left_x,
	output coord_t left_y,
	output coord_t right_x,
	output coord_t right_y,
	output coord_t read_x,
	output coord_t read_y
);

	coord_t x_mem [OPEN_DEPTH];
	coord_t y_mem [OPEN_DEPTH];
	index_t pair_next;
	logic   read_valid;

	assign pair_next = pair_index + index_t'(1);
	assign read_valid = read_addr < index_t'(OPEN_DEPTH);

	//////////////////////////////
	// write side

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			for (int i = 0; i < OPEN_DEPTH; i++)
			begin
				x_mem[i] <= '0;
				y_mem[i] <= '0;
			end
		end
		else if (swap)
		begin
			x_mem[pair_index] <= x_mem[pair_next];   // both coords move together
			y_mem[pair_index] <= y_mem[pair_next];
			x_mem[pair_next] <= x_mem[pair_index];
			y_mem[pair_next] <= y_mem[pair_index];
		end
		else if (load_en && !busy && load_addr < index_t'(OPEN_DEPTH))
		begin
			x_mem[load_addr] <= load_x;
			y_mem[load_addr] <= load_y;
		end
	end

	//////////////////////////////
	// read side

	assign left_x = x_mem[pair_index];
	assign left_y = y_mem[pair_index];
	assign right_x = x_mem[pair_next];
	assign right_y = y_mem[pair_next];

	assign read_x = read_valid ? x_mem[read_addr] : '0;   // past the end reads zero
	assign read_y = read_valid ? y_mem[read_addr] : '0;

	// a swap outside a sort would corrupt a list still being loaded
	assert property (@(posedge Clk) disable iff (Reset) swap |-> busy);

endmodule

`default_nettype wire

// File: hdl/bubble_sorter.sv
`timescale 1ns/1ps
`default_nettype none

module bubble_sorter import sort_pkg::*;
(
	input  logic   Clk,
	input  logic   Reset,
	input  logic   start,
	input  index_t entry_count,
	input  coord_t start_x,
	input  coord_t start_y,
	input  coord_t goal_x,
	input  coord_t goal_y,
	input  cost_t  left_cost,
	input  cost_t  right_cost,
	output index_t pair_index,
	output logic   swap,
	output logic   busy,
	output logic   done,
	output coord_t held_start_x,
	output coord_t held_start_y,
	output coord_t held_goal_x,
	output coord_t held_goal_y
);

	typedef enum logic [1:0]
	{
		S_IDLE,
		S_COMPARE,
		S_SWAP,
		S_NEXT
	} state_t;

	state_t state;
	index_t count_q;
	index_t count_in;
	logic   swapped;   // any exchange in the current pass
	logic   accept;
	logic   pass_end;

	assign accept = start && !busy;
	assign count_in = (entry_count > index_t'(OPEN_DEPTH)) ? index_t'(OPEN_DEPTH) : entry_count;

	// last pair is count minus 2, also true for counts 0 and 1
	assign pass_end = (pair_index + index_t'(2)) >= count_q;

	assign swap = (state == S_SWAP);

	//////////////////////////////
	// pass and compare FSM

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= S_IDLE;
			count_q <= '0;
			pair_index <= '0;
			swapped <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			case (state)
			S_IDLE:
			begin
				if (accept)
				begin
					count_q <= count_in;
					pair_index <= '0;
					swapped <= 1'b0;
					busy <= 1'b1;
					done <= 1'b0;
					// short lists skip straight to the end of pass check
					state <= (count_in < index_t'(2)) ? S_NEXT : S_COMPARE;
				end
			end
			S_COMPARE:
			begin
				if (left_cost > right_cost)   // strict, keeps ties in load order
					state <= S_SWAP;
				else
					state <= S_NEXT;
			end
			S_SWAP:
			begin
				swapped <= 1'b1;   // memory exchanges on this edge
				state <= S_NEXT;
			end
			S_NEXT:
			begin
				if (!pass_end)
				begin
					pair_index <= pair_index + index_t'(1);
					state <= S_COMPARE;
				end
				else if (swapped)
				begin
					pair_index <= '0;   // another pass
					swapped <= 1'b0;
					state <= S_COMPARE;
				end
				else
				begin
					busy <= 1'b0;
					done <= 1'b1;
					state <= S_IDLE;
				end
			end
			default:
			begin
				state <= S_IDLE;
			end
			endcase
		end
	end

	//////////////////////////////
	// points held for the whole sort

	always_ff @(posedge Clk)
	begin
		if (state == S_IDLE && accept)
		begin
			held_start_x <= start_x;
			held_start_y <= start_y;
			held_goal_x <= goal_x;
			held_goal_y <= goal_y;
		end
	end

	assert property (@(posedge Clk) disable iff (Reset) !(busy && done));

	// the memory must never be asked to exchange past the loaded entries
	assert property (@(posedge Clk) disable iff (Reset)
		swap |-> ((pair_index + index_t'(1)) < count_q));

endmodule

`default_nettype wire

// File: hdl/sort_top.sv
`timescale 1ns/1ps
`default_nettype none

module sort_top import sort_pkg::*;
(
	input  logic   Clk,
	input  logic   Reset,
	input  logic   load_en,
	input  index_t load_addr,
	input  coord_t load_x,
	input  coord_t load_y,
	input  logic   start,
	input  index_t entry_count,
	input  coord_t start_x,
	input  coord_t start_y,
	input  coord_t goal_x,
	input  coord_t goal_y,
	input  index_t read_addr,
	output coord_t read_x,
	output coord_t read_y,
	output logic   busy,
	output logic   done
);

	index_t pair_index;
	logic   swap;
	coord_t left_x;
	coord_t left_y;
	coord_t right_x;
	coord_t right_y;
	cost_t  left_cost;
	cost_t  right_cost;
	coord_t held_start_x;
	coord_t held_start_y;
	coord_t held_goal_x;
	coord_t held_goal_y;

	open_list_mem list_mem
	(
		.Clk        (Clk),
		.Reset      (Reset),
		.load_en    (load_en),
		.load_addr  (load_addr),
		.load_x     (load_x),
		.load_y     (load_y),
		.busy       (busy),
		.pair_index (pair_index),
		.swap       (swap),
		.read_addr  (read_addr),
		.left_x     (left_x),
		.left_y     (left_y),
		.right_x    (right_x),
		.right_y    (right_y),
		.read_x     (read_x),
		.read_y     (read_y)
	);

	octile_cost left_cost_unit
	(
		.node_x  (left_x),
		.node_y  (left_y),
		.start_x (held_start_x),
		.start_y (held_start_y),
		.goal_x  (held_goal_x),
		.goal_y  (held_goal_y),
		.cost    (left_cost)
	);

	octile_cost right_cost_unit
	(
		.node_x  (right_x),
		.node_y  (right_y),
		.start_x (held_start_x),
		.start_y (held_start_y),
		.goal_x  (held_goal_x),
		.goal_y  (held_goal_y),
		.cost    (right_cost)
	);

	bubble_sorter sorter
	(
		.Clk          (Clk),
		.Reset        (Reset),
		.start        (start),
		.entry_count  (entry_count),
		.start_x      (start_x),
		.start_y      (start_y),
		.goal_x       (goal_x),
		.goal_y       (goal_y),
		.left_cost    (left_cost),
		.right_cost   (right_cost),
		.pair_index   (pair_index),
		.swap         (swap),
		.busy         (busy),
		.done         (done),
		.held_start_x (held_start_x),
		.held_start_y (held_start_y),
		.held_goal_x  (held_goal_x),
		.held_goal_y  (held_goal_y)
	);

endmodule

`default_nettype wire

// File: tests/sort_tb_model.svh
`ifndef SORT_TB_MODEL_SVH
`define SORT_TB_MODEL_SVH

logic [31:0] lfsr_state = 32'h1c464289;
coord_t model_x [OPEN_DEPTH];   // mirror of the DUT list
coord_t model_y [OPEN_DEPTH];
coord_t exp_x [OPEN_DEPTH];     // expected list after a sort
coord_t exp_y [OPEN_DEPTH];

//////////////////////////////
// random source

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] rand_bits(input int width);
	logic [31:0] value;
	logic        fb;
	value = '0;
	for (int i = 0; i < width; i++)
	begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		value = {value[30:0], fb};
	end
	return value;
endfunction

//////////////////////////////
// cost and order model

// 14 * short + 10 * (long - short) rewritten as 10 * (dx + dy) - 6 * short
function automatic int octile_model(input int ax, input int ay, input int bx, input int by);
	int dx;
	int dy;
	int short_leg;
	dx = (ax > bx) ? ax - bx : bx - ax;
	dy = (ay > by) ? ay - by : by - ay;
	short_leg = (dx < dy) ? dx : dy;
	return STRAIGHT_STEP * (dx + dy) - (2 * STRAIGHT_STEP - DIAGONAL_STEP) * short_leg;
endfunction

// stable insertion sort over the first n entries only
task automatic sort_model(input int n, input coord_t sx, input coord_t sy,
	input coord_t gx, input coord_t gy);
	int     key [OPEN_DEPTH];
	int     tk;
	int     j;
	coord_t tx;
	coord_t ty;
	for (int i = 0; i < OPEN_DEPTH; i++)
	begin
		exp_x[i] = model_x[i];
		exp_y[i] = model_y[i];
		key[i] = octile_model(int'(exp_x[i]), int'(exp_y[i]), int'(sx), int'(sy))
			+ octile_model(int'(exp_x[i]), int'(exp_y[i]), int'(gx), int'(gy));
	end
	for (int i = 1; i < n; i++)
	begin
		tx = exp_x[i];
		ty = exp_y[i];
		tk = key[i];
		j = i - 1;
		while (j >= 0 && key[j] > tk)   // equal keys stay put
		begin
			exp_x[j + 1] = exp_x[j];
			exp_y[j + 1] = exp_y[j];
			key[j + 1] = key[j];
			j--;
		end
		exp_x[j + 1] = tx;
		exp_y[j + 1] = ty;
		key[j + 1] = tk;
	end
endtask

task automatic check_value(input string name, input int expected, input int actual);
	if (expected != actual)
	begin
		$display("Error %s: expected %0d, actual %0d", name, expected, actual);
		$display("FAIL: see errors above");
		$fatal(1, "value mismatch");
	end
endtask

`endif

// File: tests/sort_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sort_tb import sort_pkg::*;
();

	logic   Clk;
	logic   Reset;
	logic   load_en;
	index_t load_addr;
	coord_t load_x;
	coord_t load_y;
	logic   start;
	index_t entry_count;
	coord_t start_x;
	coord_t start_y;
	coord_t goal_x;
	coord_t goal_y;
	index_t read_addr;
	coord_t read_x;
	coord_t read_y;
	logic   busy;
	logic   done;
	int     cycle_count = 0;
	int     cycle_budget;

	`include "sort_tb_model.svh"

	sort_top DUT
	(
		.Clk         (Clk),
		.Reset       (Reset),
		.load_en     (load_en),
		.load_addr   (load_addr),
		.load_x      (load_x),
		.load_y      (load_y),
		.start       (start),
		.entry_count (entry_count),
		.start_x     (start_x),
		.start_y     (start_y),
		.goal_x      (goal_x),
		.goal_y      (goal_y),
		.read_addr   (read_addr),
		.read_x      (read_x),
		.read_y      (read_y),
		.busy        (busy),
		.done        (done)
	);

	always #10 Clk = ~Clk;

	always @(posedge Clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_budget)
		begin
			$display("Timeout: the sort never finished within %0d cycles", cycle_budget);
			$display("FAIL: see errors above");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////
	// helpers

	task automatic reserve_cycles(input int n);
		int cap;
		cap = (n > 32) ? 32 : n;
		cycle_budget += 3 * cap * cap + cap + 50;   // worst bubble sort plus load and readback
	endtask

	task automatic fill_random(input int n);
		for (int i = 0; i < n; i++)
		begin
			model_x[i] = coord_t'(rand_bits(8));
			model_y[i] = coord_t'(rand_bits(8));
		end
	endtask

	// eight points at octile distance 62 around (100, 100)
	task automatic fill_ties();
		int off_a [8] = '{5, 3, -5, -3, 5, 3, -5, -3};
		int off_b [8] = '{3, 5, 3, 5, -3, -5, -3, -5};
		for (int i = 0; i < 8; i++)
		begin
			model_x[i] = coord_t'(100 + off_a[i]);
			model_y[i] = coord_t'(100 + off_b[i]);
		end
	endtask

	task automatic adopt_expected();
		for (int i = 0; i < OPEN_DEPTH; i++)
		begin
			model_x[i] = exp_x[i];
			model_y[i] = exp_y[i];
		end
	endtask

	task automatic load_list(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(negedge Clk);
			load_en = 1'b1;
			load_addr = index_t'(i);
			load_x = model_x[i];
			load_y = model_y[i];
		end
		@(negedge Clk);
		load_en = 1'b0;
	endtask

	task automatic start_sort(input int n, input coord_t sx, input coord_t sy,
		input coord_t gx, input coord_t gy);
		@(negedge Clk);
		start = 1'b1;
		entry_count = index_t'(n);
		start_x = sx;
		start_y = sy;
		goal_x = gx;
		goal_y = gy;
		@(negedge Clk);
		start = 1'b0;
		check_value("busy after start", 1, int'(busy));
		check_value("done after start", 0, int'(done));
	endtask

	task automatic wait_done();
		while (!done)
			@(negedge Clk);
		check_value("busy at done", 0, int'(busy));
	endtask

	// address set on one falling edge, checked on the next
	task automatic readback(input string name, input int m);
		for (int i = 0; i <= m; i++)
		begin
			@(negedge Clk);
			if (i > 0)
			begin
				check_value($sformatf("%s x at %0d", name, i - 1), int'(exp_x[i - 1]), int'(read_x));
				check_value($sformatf("%s y at %0d", name, i - 1), int'(exp_y[i - 1]), int'(read_y));
			end
			if (i < m)
				read_addr = index_t'(i);
		end
		adopt_expected();
	endtask

	task automatic sort_and_check(input string name, input int n, input int m,
		input coord_t sx, input coord_t sy, input coord_t gx, input coord_t gy);
		start_sort(n, sx, sy, gx, gy);
		wait_done();
		sort_model(n, sx, sy, gx, gy);
		readback(name, m);
	endtask

	//////////////////////////////
	// test sequence

	initial
	begin
		int     n;
		coord_t sx;
		coord_t sy;
		coord_t gx;
		coord_t gy;
		Clk = 1'b0;
		Reset = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_x = '0;
		load_y = '0;
		start = 1'b0;
		entry_count = '0;
		start_x = '0;
		start_y = '0;
		goal_x = '0;
		goal_y = '0;
		read_addr = '0;
		cycle_budget = 0;
		for (int i = 0; i < OPEN_DEPTH; i++)
		begin
			model_x[i] = '0;   // list clears on reset
			model_y[i] = '0;
		end
		reserve_cycles(0);
		repeat (3) @(posedge Clk);
		@(negedge Clk);
		Reset = 1'b0;
		@(negedge Clk);
		check_value("busy after reset", 0, int'(busy));
		check_value("done after reset", 0, int'(done));

		for (int t = 0; t < 8; t++)
		begin
			n = 2 + int'(rand_bits(5)) % 31;
			reserve_cycles(n);
			fill_random(n);
			load_list(n);
			sx = coord_t'(rand_bits(8));
			sy = coord_t'(rand_bits(8));
			gx = coord_t'(rand_bits(8));
			gy = coord_t'(rand_bits(8));
			sort_and_check($sformatf("random %0d", t), n, n, sx, sy, gx, gy);
		end

		// equal costs keep load order
		reserve_cycles(8);
		fill_ties();
		load_list(8);
		sort_and_check("ties", 8, 8, 8'd100, 8'd100, 8'd100, 8'd100);

		reserve_cycles(16);
		fill_random(16);
		sort_model(16, 8'd20, 8'd30, 8'd200, 8'd180);
		adopt_expected();   // already ascending before load
		load_list(16);
		sort_and_check("ordered", 16, 16, 8'd20, 8'd30, 8'd200, 8'd180);

		reserve_cycles(6);
		fill_random(6);
		load_list(6);
		sort_and_check("count one", 1, 6, 8'd0, 8'd0, 8'd255, 8'd255);
		reserve_cycles(0);
		sort_and_check("count zero", 0, 6, 8'd255, 8'd0, 8'd0, 8'd255);

		//////////////////////////////
		// loads during a sort and re-sort

		reserve_cycles(24);
		fill_random(24);
		load_list(24);
		sx = coord_t'(rand_bits(8));
		sy = coord_t'(rand_bits(8));
		gx = coord_t'(rand_bits(8));
		gy = coord_t'(rand_bits(8));
		start_sort(24, sx, sy, gx, gy);
		for (int k = 0; k < 6; k++)
		begin
			@(negedge Clk);
			check_value("busy during loads", 1, int'(busy));
			load_en = 1'b1;
			load_addr = index_t'(k);
			load_x = 8'hee;   // must never land
			load_y = 8'h11;
		end
		@(negedge Clk);
		load_en = 1'b0;
		wait_done();
		sort_model(24, sx, sy, gx, gy);
		readback("loads while busy", 24);

		reserve_cycles(20);
		fill_random(20);
		load_list(20);
		sx = coord_t'(rand_bits(8));
		sy = coord_t'(rand_bits(8));
		gx = coord_t'(rand_bits(8));
		gy = coord_t'(rand_bits(8));
		sort_and_check("first sort", 20, 20, sx, sy, gx, gy);
		check_value("done before re-sort", 1, int'(done));
		reserve_cycles(20);
		sort_and_check("re-sort", 20, 20, sx + 8'd37, sy + 8'd91, gx + 8'd53, gy + 8'd17);

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+tests
hdl/sort_pkg.sv
hdl/octile_cost.sv
hdl/open_list_mem.sv
hdl/bubble_sorter.sv
hdl/sort_top.sv
tests/sort_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= sort_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
